//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_top -f sim.f -Mdir obj_dir -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

//--- sim.f
verilog/mmr_pkg.sv
verilog/qspi_pkg.sv
verilog/axil_slave_port.sv
verilog/mmr_decoder.sv
verilog/scratch_mem.sv
verilog/qspi_master.sv
verilog/top.sv
test/tb_clk_gen.sv
test/tb_top_sva.sv
test/tb_top.sv

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_NS = 10;  // 20 ns period

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int N_MEM = 200;
    localparam int N_UNMAP = 20;
    localparam int N_QSPI = 12;
    localparam int N_BP = 40;
    localparam int N_LAT = 20;
    localparam int WAIT_MAX = 64;  // Cycles before a handshake counts as lost
    // About 20 accesses per QSPI transfer with polling and 24 cycles worst case each
    localparam int N_ACCESS = 2 * (N_MEM + N_BP) + 3 * N_UNMAP + 20 * N_QSPI + N_LAT;
    localparam int WD_CYCLES = N_ACCESS * 24 + 2000;
    localparam logic [11:0] A_CTRL = {mmr_pkg::MMR_QSPI, 4'd0, qspi_pkg::QSPI_CTRL, 2'b00};
    localparam logic [11:0] A_TX = {mmr_pkg::MMR_QSPI, 4'd0, qspi_pkg::QSPI_TX, 2'b00};
    localparam logic [11:0] A_RX = {mmr_pkg::MMR_QSPI, 4'd0, qspi_pkg::QSPI_RX, 2'b00};
    localparam logic [11:0] A_STAT = {mmr_pkg::MMR_QSPI, 4'd0, qspi_pkg::QSPI_STAT, 2'b00};

    logic aclk;
    logic rst_n;
    logic [mmr_pkg::MMR_ADDR_W-1:0] awaddr, araddr;
    logic [mmr_pkg::MMR_DATA_W-1:0] wdata, rdata;
    logic [mmr_pkg::MMR_STRB_W-1:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    logic SCK, CSn;
    logic [qspi_pkg::SPI_W-1:0] MOSI, MISO;

    logic [31:0] seed = 32'ha142;
    logic [31:0] mem_model [mmr_pkg::MMR_MEM_WORDS];
    int errors = 0;
    int tests_run = 0;
    int sck_rises = 0;

    tb_clk_gen clk_i (.clk(aclk));

    top uut (
        .aclk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .SCK, .CSn, .MOSI, .MISO
    );

    always @(negedge aclk) MISO <= ~MOSI;  // Slave answers with inverted lanes
    always @(posedge SCK) sck_rises <= sck_rises + 1;

    function automatic logic [31:0] lcg_step();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick(input int range);
        logic [31:0] r;
        r = lcg_step();
        return int'(r[31:16]) % range;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi, lo;
        hi = lcg_step();
        lo = lcg_step();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("%0t %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input string name, input int mark);
        tests_run++;
        $display("test %s done with %0d errors", name, errors - mark);
    endtask

    // Entered on the first falling edge after the request handshake
    task automatic take_response(input logic is_wr, input int delay,
                                 output logic [31:0] data, output logic [1:0] resp,
                                 output int lat);
        logic valid;
        lat = 0;
        data = '0;
        resp = '0;
        for (int n = 1; n <= WAIT_MAX; n++) begin
            valid = is_wr ? bvalid : rvalid;
            if (valid && lat == 0) begin
                lat = n;
                data = rdata;
                resp = is_wr ? bresp : rresp;
            end else if (valid) begin
                if (!is_wr && rdata !== data)
                    flag_mismatch("rdata", data, rdata);
                if ((is_wr ? bresp : rresp) !== resp)
                    flag_mismatch("resp", 32'(resp), 32'(is_wr ? bresp : rresp));
            end else if (lat != 0) begin
                note_failure("response valid dropped before ready");
                return;
            end
            if (valid && (awready || wready || arready))
                note_failure("bus accepted a request while a response was pending");
            if (valid && n - lat >= delay) begin
                bready = is_wr;
                rready = !is_wr;
                @(negedge aclk);
                bready = 1'b0;
                rready = 1'b0;
                if (bvalid || rvalid)
                    note_failure("response valid still high after its handshake");
                return;
            end
            @(negedge aclk);
        end
        note_failure("no response within the wait limit");
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int delay,
                             output logic [1:0] resp);
        int aw_skew, w_skew, n, lat;
        logic aw_done, w_done, aw_go, w_go;
        logic [31:0] unused;
        aw_skew = pick(3);
        w_skew = pick(3);
        aw_done = 1'b0;
        w_done = 1'b0;
        n = 0;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        while (!(aw_done && w_done)) begin
            awvalid = !aw_done && n >= aw_skew;
            wvalid = !w_done && n >= w_skew;
            #1;
            aw_go = awvalid && awready;
            w_go = wvalid && wready;
            @(negedge aclk);
            aw_done = aw_done || aw_go;
            w_done = w_done || w_go;
            n++;
            if (n > WAIT_MAX) begin
                note_failure("write address or data never accepted");
                break;
            end
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        take_response(1'b1, delay, unused, resp, lat);
    endtask

    task automatic bus_read(input logic [11:0] addr, input int delay,
                            output logic [31:0] data, output logic [1:0] resp,
                            output int lat);
        logic ar_go;
        araddr = addr;
        arvalid = 1'b1;
        ar_go = 1'b0;
        for (int n = 0; n < WAIT_MAX && !ar_go; n++) begin
            #1;
            ar_go = arready;
            @(negedge aclk);
        end
        arvalid = 1'b0;
        if (!ar_go)
            note_failure("read address never accepted");
        take_response(1'b0, delay, data, resp, lat);
    endtask

    // Random write followed by a readback against the model
    task automatic scratch_round(input int max_delay);
        logic [5:0] word;
        logic [31:0] data;
        logic [3:0] strb;
        logic [1:0] resp;
        int lat;
        word = 6'(pick(64));
        data = rand_word();
        strb = 4'(pick(16));
        bus_write({mmr_pkg::MMR_SYS, word, 2'b00}, data, strb, pick(max_delay + 1), resp);
        mem_model[word] = apply_strobes(mem_model[word], data, strb);
        if (resp !== mmr_pkg::RESP_OKAY)
            flag_mismatch("bresp", 32'(mmr_pkg::RESP_OKAY), 32'(resp));
        bus_read({mmr_pkg::MMR_SYS, word, 2'b00}, pick(max_delay + 1), data, resp, lat);
        if (data !== mem_model[word])
            flag_mismatch("rdata", mem_model[word], data);
        if (resp !== mmr_pkg::RESP_OKAY)
            flag_mismatch("rresp", 32'(mmr_pkg::RESP_OKAY), 32'(resp));
    endtask

    initial begin
        int mark, lat, n_nib, rises, polls, sva_fails;
        logic [31:0] data, tx, exp;
        logic [1:0] resp;
        logic [5:0] word;
        logic [3:0] slot, cnt;
        logic [7:0] div;
        logic hold;

        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        MISO = '0;
        for (int i = 0; i < mmr_pkg::MMR_MEM_WORDS; i++)
            mem_model[i] = '0;
        repeat (10) @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);

        mark = errors;
        if ({awready, wready, arready} !== 3'b111)
            flag_mismatch("awready/wready/arready", 32'd7, 32'({awready, wready, arready}));
        if ({bvalid, rvalid} !== 2'b00)
            flag_mismatch("bvalid/rvalid", 32'd0, 32'({bvalid, rvalid}));
        if (CSn !== 1'b1)
            flag_mismatch("CSn", 32'd1, 32'(CSn));
        if (SCK !== 1'b0)
            flag_mismatch("SCK", 32'd0, 32'(SCK));
        close_test("reset_state", mark);

        mark = errors;
        repeat (N_MEM) scratch_round(0);
        close_test("scratch_memory", mark);

        mark = errors;
        repeat (N_UNMAP) begin
            slot = 4'(2 + pick(14));
            word = 6'(pick(64));
            bus_write({slot, word, 2'b00}, rand_word(), 4'hf, pick(2), resp);
            if (resp !== mmr_pkg::RESP_SLVERR)
                flag_mismatch("bresp", 32'(mmr_pkg::RESP_SLVERR), 32'(resp));
            bus_read({slot, word, 2'b00}, pick(2), data, resp, lat);
            if (resp !== mmr_pkg::RESP_SLVERR)
                flag_mismatch("rresp", 32'(mmr_pkg::RESP_SLVERR), 32'(resp));
            if (data !== 32'd0)
                flag_mismatch("rdata", 32'd0, data);
            bus_read({mmr_pkg::MMR_SYS, word, 2'b00}, 0, data, resp, lat);
            if (data !== mem_model[word])
                flag_mismatch("rdata", mem_model[word], data);  // Memory left alone
        end
        close_test("unmapped_slots", mark);

        mark = errors;
        repeat (N_QSPI) begin
            tx = rand_word();
            cnt = 4'(pick(9));
            div = 8'(pick(4));
            hold = pick(4) == 0;
            n_nib = (cnt == 4'd0) ? 8 : int'(cnt);
            bus_write(A_TX, tx, 4'hf, 0, resp);
            rises = sck_rises;
            bus_write(A_CTRL, {15'd0, hold, cnt, div, 3'd0, 1'b1}, 4'hf, 0, resp);
            polls = 0;
            do begin
                bus_read(A_STAT, 0, data, resp, lat);
                polls++;
            end while (data[0] && polls < 200);
            if (data[0])
                note_failure("QSPI busy never cleared");
            rises = sck_rises - rises;
            if (rises != n_nib)
                flag_mismatch("SCK rises", n_nib, rises);
            bus_read(A_RX, 0, data, resp, lat);
            exp = (~tx) >> (32 - 4 * n_nib);  // Inverted nibbles right-aligned
            if (data !== exp)
                flag_mismatch("rx", exp, data);
            if (CSn !== !hold)
                flag_mismatch("CSn", 32'(!hold), 32'(CSn));
            if (hold) begin
                bus_write(A_CTRL, 32'd0, 4'hf, 0, resp);  // Release held select
                if (CSn !== 1'b1)
                    flag_mismatch("CSn", 32'd1, 32'(CSn));
            end
        end
        close_test("qspi_transfers", mark);

        mark = errors;
        repeat (N_BP) scratch_round(7);
        close_test("back_pressure", mark);

        mark = errors;
        repeat (N_LAT) begin
            word = 6'(pick(64));
            bus_read({mmr_pkg::MMR_SYS, word, 2'b00}, 0, data, resp, lat);
            if (lat != 3)
                flag_mismatch("rvalid latency", 32'd3, lat);
            if (data !== mem_model[word])
                flag_mismatch("rdata", mem_model[word], data);
        end
        close_test("read_latency", mark);

        sva_fails = uut.sva_i.fail_count;
        errors += sva_fails;
        $display("%0d tests run, %0d errors, %0d from assertions", tests_run, errors, sva_fails);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", WD_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- test/tb_top_sva.sv
`timescale 1ns/1ps

module tb_top_sva (
    input logic                          aclk,
    input logic                          rst_n,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          rvalid,
    input logic                          rready,
    input logic [mmr_pkg::MMR_DATA_W-1:0] rdata,
    input logic                          SCK,
    input logic                          CSn
);

    int fail_count = 0;  // Read by the testbench summary

    // SPI pins idle in the first cycle out of reset
    a_reset_pins: assert property (@(posedge aclk) $rose(rst_n) |-> CSn && !SCK)
        else begin
            fail_count++;
            $error("SPI pins not idle after reset");
        end

    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    a_rdata_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else begin
            fail_count++;
            $error("rdata changed while stalled");
        end

    a_sck_idle: assert property (@(posedge aclk) disable iff (!rst_n) CSn |-> !SCK)
        else begin
            fail_count++;
            $error("SCK toggling with CSn high");
        end

endmodule

bind top tb_top_sva sva_i (
    .aclk, .rst_n, .bvalid, .bready, .rvalid, .rready, .rdata, .SCK, .CSn
);

//--- verilog/axil_slave_port.sv
`timescale 1ns/1ps

module axil_slave_port (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic [mmr_pkg::MMR_ADDR_W-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [mmr_pkg::MMR_DATA_W-1:0] wdata,
    input  logic [mmr_pkg::MMR_STRB_W-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [mmr_pkg::MMR_ADDR_W-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [mmr_pkg::MMR_DATA_W-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          req_valid,
    output logic                          req_write,
    output logic [mmr_pkg::MMR_ADDR_W-1:0] req_addr,
    output logic [mmr_pkg::MMR_DATA_W-1:0] req_wdata,
    output logic [mmr_pkg::MMR_STRB_W-1:0] req_wstrb,
    input  logic                          rsp_valid,
    input  logic [mmr_pkg::MMR_DATA_W-1:0] rsp_rdata,
    input  logic                          rsp_err
);

    logic aw_seen, w_seen, is_write;
    logic wait_rsp, resp_pend, idle;
    logic aw_hs, w_hs, ar_hs, wr_go;
    logic [1:0] resp;

    assign idle = !(req_valid || wait_rsp || resp_pend);
    assign awready = idle && !aw_seen;
    assign wready = idle && !w_seen;
    // Write wins, so no read once either write half shows up
    assign arready = idle && !aw_seen && !w_seen && !awvalid && !wvalid;

    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;
    assign ar_hs = arvalid && arready;
    assign wr_go = (aw_seen || aw_hs) && (w_seen || w_hs);

    assign bvalid = resp_pend && is_write;
    assign rvalid = resp_pend && !is_write;
    assign bresp = resp;
    assign rresp = resp;
    assign req_write = is_write;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            aw_seen <= 1'b0;
            w_seen <= 1'b0;
            is_write <= 1'b0;
            req_valid <= 1'b0;
            wait_rsp <= 1'b0;
            resp_pend <= 1'b0;
        end else begin
            req_valid <= 1'b0;  // One-cycle pulse
            if (wr_go) begin
                req_valid <= 1'b1;
                is_write <= 1'b1;
                aw_seen <= 1'b0;
                w_seen <= 1'b0;
            end else if (ar_hs) begin
                req_valid <= 1'b1;
                is_write <= 1'b0;
            end else begin
                if (aw_hs) aw_seen <= 1'b1;
                if (w_hs) w_seen <= 1'b1;
            end
            if (req_valid) wait_rsp <= 1'b1;
            if (wait_rsp && rsp_valid) begin
                wait_rsp <= 1'b0;
                resp_pend <= 1'b1;
            end
            if ((bvalid && bready) || (rvalid && rready)) resp_pend <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) req_addr <= awaddr;
        else if (ar_hs) req_addr <= araddr;
        if (w_hs) begin
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end
        if (wait_rsp && rsp_valid) begin  // Held until taken
            rdata <= rsp_rdata;
            resp <= rsp_err ? mmr_pkg::RESP_SLVERR : mmr_pkg::RESP_OKAY;
        end
    end

endmodule

//--- verilog/mmr_decoder.sv
`timescale 1ns/1ps

module mmr_decoder (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  logic                           req_write,
    input  logic [mmr_pkg::MMR_ADDR_W-1:0]  req_addr,
    input  logic [mmr_pkg::MMR_DATA_W-1:0]  req_wdata,
    input  logic [mmr_pkg::MMR_STRB_W-1:0]  req_wstrb,
    input  logic [mmr_pkg::MMR_DATA_W-1:0]  mem_rdata,
    input  logic [mmr_pkg::MMR_DATA_W-1:0]  qspi_rdata,
    output logic                           sel_mem,
    output logic                           sel_qspi,
    output logic                           write,
    output logic [mmr_pkg::MMR_WADDR_W-1:0] word_addr,
    output logic [mmr_pkg::MMR_DATA_W-1:0]  wdata,
    output logic [mmr_pkg::MMR_STRB_W-1:0]  wstrb,
    output logic                           rsp_valid,
    output logic [mmr_pkg::MMR_DATA_W-1:0]  rsp_rdata,
    output logic                           rsp_err
);

    logic [mmr_pkg::MMR_SLOT_W-1:0] slot;
    logic hit_mem, hit_qspi;
    logic qspi_q, err_q;

    assign slot = req_addr[mmr_pkg::MMR_ADDR_W-1:mmr_pkg::MMR_SLOT_LSB];
    assign hit_mem = slot == mmr_pkg::MMR_SYS;
    assign hit_qspi = slot == mmr_pkg::MMR_QSPI;

    // Device selects in the request cycle
    assign sel_mem = req_valid && hit_mem;
    assign sel_qspi = req_valid && hit_qspi;
    assign write = req_write;
    assign word_addr = req_addr[mmr_pkg::MMR_SLOT_LSB-1:2];
    assign wdata = req_wdata;
    assign wstrb = req_wstrb;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            qspi_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            if (req_valid) begin
                qspi_q <= hit_qspi;
                err_q <= !(hit_mem || hit_qspi);  // Unmapped slot
            end
        end
    end

    // Devices answer one cycle after select
    always_comb begin
        if (err_q)
            rsp_rdata = '0;
        else if (qspi_q)
            rsp_rdata = qspi_rdata;
        else
            rsp_rdata = mem_rdata;
    end

    assign rsp_err = err_q;

endmodule

//--- verilog/mmr_pkg.sv
package mmr_pkg;

    // Register bus
    localparam int MMR_ADDR_W = 12;
    localparam int MMR_DATA_W = 32;
    localparam int MMR_STRB_W = MMR_DATA_W / 8;

    // Slot in bits 11:8 and word in bits 7:2
    localparam int MMR_SLOT_LSB = 8;
    localparam int MMR_SLOT_W = MMR_ADDR_W - MMR_SLOT_LSB;
    localparam int MMR_MEM_WORDS = 64;
    localparam int MMR_WADDR_W = $clog2(MMR_MEM_WORDS);

    // Only these device slots are mapped
    localparam logic [MMR_SLOT_W-1:0] MMR_SYS = 4'd0;   // Scratch memory
    localparam logic [MMR_SLOT_W-1:0] MMR_QSPI = 4'd1;  // QSPI master

    // Response codes as on the AXI bus
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- verilog/qspi_master.sv
`timescale 1ns/1ps

module qspi_master (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           sel_qspi,
    input  logic                           write,
    input  logic [mmr_pkg::MMR_WADDR_W-1:0] word_addr,
    input  logic [mmr_pkg::MMR_DATA_W-1:0]  wdata,
    input  logic [mmr_pkg::MMR_STRB_W-1:0]  wstrb,
    output logic [mmr_pkg::MMR_DATA_W-1:0]  qspi_rdata,
    output logic                           SCK,
    output logic                           CSn,
    output logic [qspi_pkg::SPI_W-1:0]      MOSI,
    input  logic [qspi_pkg::SPI_W-1:0]      MISO
);

    qspi_pkg::qspi_ctrl_u ctrl_q, ctrl_wr;
    logic [mmr_pkg::MMR_DATA_W-1:0] tx_q, rx_q, shift_q;
    logic [1:0] offset;
    logic [7:0] div_cnt;
    logic [3:0] nib_left;
    logic busy, ctrl_we, start, half_done;

    function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign offset = word_addr[1:0];
    assign ctrl_we = sel_qspi && write && offset == qspi_pkg::QSPI_CTRL;
    always_comb ctrl_wr.raw = merge(ctrl_q.raw, wdata, wstrb);
    assign start = ctrl_we && ctrl_wr.f.start && !busy;  // Ignored while busy
    assign half_done = busy && div_cnt == ctrl_q.f.div;
    assign MOSI = shift_q[31:28];  // MS nibble first

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q.raw <= '0;
            shift_q <= '0;
            busy <= 1'b0;
            SCK <= 1'b0;
            CSn <= 1'b1;
            div_cnt <= '0;
            nib_left <= '0;
        end else if (busy) begin
            if (half_done) begin
                div_cnt <= '0;
                SCK <= !SCK;
                if (SCK) begin  // Falling edge shifts the next nibble out
                    shift_q <= shift_q << qspi_pkg::SPI_W;
                    nib_left <= nib_left - 4'd1;
                    if (nib_left == 4'd1) begin
                        busy <= 1'b0;
                        CSn <= !ctrl_q.f.cs_hold;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end else if (ctrl_we) begin
            ctrl_q.raw <= ctrl_wr.raw;
            ctrl_q.f.start <= 1'b0;  // Strobe only
            if (start) begin
                busy <= 1'b1;
                CSn <= 1'b0;
                SCK <= 1'b0;
                div_cnt <= '0;
                shift_q <= tx_q;
                nib_left <= (ctrl_wr.f.count == 4'd0) ? 4'd8 : ctrl_wr.f.count;
            end else if (!ctrl_wr.f.cs_hold) begin
                CSn <= 1'b1;  // Drop a held select
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (sel_qspi && write && offset == qspi_pkg::QSPI_TX && !busy)
            tx_q <= merge(tx_q, wdata, wstrb);
        if (start)
            rx_q <= '0;
        else if (half_done && !SCK)  // Sample on rising SCK
            rx_q <= {rx_q[mmr_pkg::MMR_DATA_W-qspi_pkg::SPI_W-1:0], MISO};
        if (sel_qspi && !write) begin
            case (offset)
                qspi_pkg::QSPI_CTRL: qspi_rdata <= ctrl_q.raw;
                qspi_pkg::QSPI_TX:   qspi_rdata <= tx_q;
                qspi_pkg::QSPI_RX:   qspi_rdata <= rx_q;
                qspi_pkg::QSPI_STAT: qspi_rdata <= {31'd0, busy};
            endcase
        end
    end

endmodule

//--- verilog/qspi_pkg.sv
package qspi_pkg;

    localparam int SPI_W = 4;  // Data lanes

    // Word offsets inside the QSPI slot
    localparam logic [1:0] QSPI_CTRL = 2'd0;
    localparam logic [1:0] QSPI_TX = 2'd1;
    localparam logic [1:0] QSPI_RX = 2'd2;
    localparam logic [1:0] QSPI_STAT = 2'd3;

    typedef struct packed {
        logic [14:0] rsvd_hi;
        logic        cs_hold;  // Keep CSn low after the shift
        logic [3:0]  count;    // Nibbles where 0 means 8
        logic [7:0]  div;      // SCK half period minus one
        logic [2:0]  rsvd_lo;
        logic        start;
    } qspi_ctrl_s;

    // Bus side writes the raw word and the engine reads the fields
    typedef union packed {
        logic [31:0] raw;
        qspi_ctrl_s  f;
    } qspi_ctrl_u;

endpackage

//--- verilog/scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           sel_mem,
    input  logic                           write,
    input  logic [mmr_pkg::MMR_WADDR_W-1:0] word_addr,
    input  logic [mmr_pkg::MMR_DATA_W-1:0]  wdata,
    input  logic [mmr_pkg::MMR_STRB_W-1:0]  wstrb,
    output logic [mmr_pkg::MMR_DATA_W-1:0]  mem_rdata
);

    logic [mmr_pkg::MMR_DATA_W-1:0] mem [mmr_pkg::MMR_MEM_WORDS];

    // Cleared on reset so readback is known
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mmr_pkg::MMR_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (sel_mem && write) begin
            for (int b = 0; b < mmr_pkg::MMR_STRB_W; b++) begin
                if (wstrb[b])
                    mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (sel_mem && !write) mem_rdata <= mem[word_addr];  // One cycle latency
    end

endmodule

//--- verilog/top.sv
`timescale 1ns/1ps

module top (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic [mmr_pkg::MMR_ADDR_W-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [mmr_pkg::MMR_DATA_W-1:0] wdata,
    input  logic [mmr_pkg::MMR_STRB_W-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [mmr_pkg::MMR_ADDR_W-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [mmr_pkg::MMR_DATA_W-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          SCK,
    output logic                          CSn,
    output logic [qspi_pkg::SPI_W-1:0]     MOSI,
    input  logic [qspi_pkg::SPI_W-1:0]     MISO
);

    logic req_valid, req_write, rsp_valid, rsp_err;
    logic [mmr_pkg::MMR_ADDR_W-1:0] req_addr;
    logic [mmr_pkg::MMR_DATA_W-1:0] req_wdata, rsp_rdata;
    logic [mmr_pkg::MMR_STRB_W-1:0] req_wstrb;

    // Device side
    logic sel_mem, sel_qspi, write;
    logic [mmr_pkg::MMR_WADDR_W-1:0] word_addr;
    logic [mmr_pkg::MMR_DATA_W-1:0] dev_wdata, mem_rdata, qspi_rdata;
    logic [mmr_pkg::MMR_STRB_W-1:0] dev_wstrb;

    axil_slave_port port_i (
        .aclk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
        .rsp_valid, .rsp_rdata, .rsp_err
    );

    mmr_decoder decoder_i (
        .aclk, .rst_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
        .mem_rdata, .qspi_rdata,
        .sel_mem, .sel_qspi, .write, .word_addr,
        .wdata(dev_wdata), .wstrb(dev_wstrb),
        .rsp_valid, .rsp_rdata, .rsp_err
    );

    scratch_mem mem_i (
        .aclk, .rst_n, .sel_mem, .write, .word_addr,
        .wdata(dev_wdata), .wstrb(dev_wstrb), .mem_rdata
    );

    qspi_master qspi_i (
        .aclk, .rst_n, .sel_qspi, .write, .word_addr,
        .wdata(dev_wdata), .wstrb(dev_wstrb), .qspi_rdata,
        .SCK, .CSn, .MOSI, .MISO
    );

endmodule
